// ==== fm_synth.f ====
+incdir+.
fm_pkg.sv
fm_regs.sv
fm_timer.sv
fm_phase.sv
fm_operator.sv
fm_mixer.sv
fm_synth.sv
tb_fm_synth.sv

// ==== tb_fm_tests.svh ====
`ifndef TB_FM_TESTS_SVH
`define TB_FM_TESTS_SVH

task automatic reset_test();
	check_byte("reset status", 8'h00, dout);
	check_bit("reset irq_n", 1'b1, irq_n);
	check_sample("reset left", '0, snd_left);
	check_sample("reset right", '0, snd_right);
	wait_samples(1);
	// Strobe repeats on every third clock
	for (int i = 0; i < 4; i++) begin
		@(negedge clk);
		check_bit("strobe gap 1", 1'b0, snd_sample);
		@(negedge clk);
		check_bit("strobe gap 2", 1'b0, snd_sample);
		@(negedge clk);
		check_bit("strobe period", 1'b1, snd_sample);
	end
	check_sample("idle left", '0, snd_left);
	check_sample("idle right", '0, snd_right);
endtask

task automatic busy_test();
	bus_write(`FM_REG_TL, 8'h00);
	check_byte("busy clock 1", 8'h80, dout);
	@(negedge clk);
	check_byte("busy clock 2", 8'h80, dout);
	@(negedge clk);
	check_byte("busy clock 3", 8'h80, dout);
	@(negedge clk);
	check_byte("busy released", 8'h00, dout);
endtask

task automatic timer_a_test();
	logic [31:0] r;
	logic [9:0]  val;
	int          limit;
	r   = next_rand();
	val = r[9:0];
	// At most one frame per tick, flag may follow one clock later
	limit = 3 * (1024 - int'(val)) + 1;
	bus_write(`FM_REG_TA_HI, val[9:2]);
	bus_write(`FM_REG_TA_LO, {6'd0, val[1:0]});
	bus_write(`FM_REG_TCTRL, 8'h05);
	wait_status(0, 1'b1, limit, "timer A flag");
	check_bit("timer A irq", 1'b0, irq_n);
	// Stop the timer and clear its flag, irq stays enabled
	bus_write(`FM_REG_TCTRL, 8'h14);
	wait_status(0, 1'b0, 4, "timer A flag clear");
	check_bit("timer A irq released", 1'b1, irq_n);
endtask

task automatic timer_b_test();
	logic [31:0] r;
	logic [7:0]  val;
	int          limit;
	int          cycles;
	logic        irq_high;
	r        = next_rand();
	val      = r[7:0];
	limit    = 3 * `FM_TB_PRESCALE * (256 - int'(val) + 1) + 8;
	cycles   = 0;
	irq_high = 1'b1;
	bus_write(`FM_REG_TB, val);
	bus_write(`FM_REG_TCTRL, 8'h02);
	while (!dout[1] && cycles < limit) begin
		@(negedge clk);
		cycles++;
		irq_high = irq_high & irq_n;
	end
	if (!dout[1]) begin
		other_errors++;
		$display("Timed out after %0d clocks waiting for timer B flag", limit);
	end
	check_bit("timer B irq masked", 1'b1, irq_high);
	bus_write(`FM_REG_TCTRL, 8'h20);
	wait_status(1, 1'b0, 4, "timer B flag clear");
endtask

task automatic pan_key_test();
	logic [31:0] r;
	logic        heard;
	r     = next_rand();
	heard = 1'b0;
	// Block of 4 or more and fnum above 0xFF keep the phase moving
	bus_write(`FM_REG_FNUM_HI, {2'b00, 1'b1, r[13:12], r[10:9], 1'b1});
	bus_write(`FM_REG_FNUM_LO, r[7:0]);
	bus_write(`FM_REG_TL, 8'h00);
	bus_write(`FM_REG_PAN, 8'hC0);
	bus_write(`FM_REG_KEY, 8'hF0);
	wait_samples(1);
	for (int i = 0; i < 12; i++) begin
		wait_samples(1);
		check_sample("both pans", snd_left, snd_right);
		if (snd_left != 0) begin
			heard = 1'b1;
		end
	end
	if (!heard) begin
		other_errors++;
		$display("Keyed-on channel stayed silent for 12 samples");
	end
	bus_write(`FM_REG_PAN, 8'h40);
	wait_samples(1);
	for (int i = 0; i < 6; i++) begin
		wait_samples(1);
		check_sample("right pan only", '0, snd_left);
	end
	bus_write(`FM_REG_KEY, 8'h00);
	wait_samples(1);
	for (int i = 0; i < 3; i++) begin
		wait_samples(1);
		check_sample("key off left", '0, snd_left);
		check_sample("key off right", '0, snd_right);
	end
endtask

task automatic attenuation_test();
	logic [31:0] r;
	for (int ch = 0; ch < `FM_CHANNELS; ch++) begin
		r = next_rand();
		bus_write(8'(`FM_REG_FNUM_HI + ch), {2'b00, r[13:8]});
		bus_write(8'(`FM_REG_FNUM_LO + ch), r[7:0]);
		bus_write(8'(`FM_REG_TL + ch), 8'h7F);
		bus_write(8'(`FM_REG_PAN + ch), 8'hC0);
		bus_write(`FM_REG_KEY, 8'(8'hF0 | ch));
	end
	wait_samples(1);
	// Three channels at 511 >> 7 each
	for (int i = 0; i < 12; i++) begin
		wait_samples(1);
		check_magnitude("TL 127 left", 9, snd_left);
		check_magnitude("TL 127 right", 9, snd_right);
	end
	for (int ch = 0; ch < `FM_CHANNELS; ch++) begin
		bus_write(`FM_REG_KEY, 8'(ch));
	end
endtask

`endif

// ==== tb_fm_synth.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module tb_fm_synth;

	import fm_pkg::*;

	logic        clk;
	logic        rst;
	logic [7:0]  din;
	logic [1:0]  addr;
	logic        cs_n;
	logic        wr_n;
	logic [7:0]  dout;
	logic        irq_n;
	sample_t     snd_left;
	sample_t     snd_right;
	logic        snd_sample;

	int          mismatches;
	int          other_errors;
	logic [31:0] rng_state;

	fm_synth UUT (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.din        ( din        ),
		.addr       ( addr       ),
		.cs_n       ( cs_n       ),
		.wr_n       ( wr_n       ),
		.dout       ( dout       ),
		.irq_n      ( irq_n      ),
		.snd_left   ( snd_left   ),
		.snd_right  ( snd_right  ),
		.snd_sample ( snd_sample )
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// Address cycle then data cycle, one clock each
	task automatic bus_write(input logic [7:0] reg_addr, input logic [7:0] data);
		@(negedge clk);
		addr = 2'd0;
		din  = reg_addr;
		cs_n = 1'b0;
		wr_n = 1'b0;
		@(negedge clk);
		addr = 2'd1;
		din  = data;
		@(negedge clk);
		cs_n = 1'b1;
		wr_n = 1'b1;
	endtask

	task automatic wait_samples(input int n);
		int seen;
		int cycles;
		seen   = 0;
		cycles = 0;
		while (seen < n && cycles < n * 3 + 10) begin
			@(negedge clk);
			cycles++;
			if (snd_sample) begin
				seen++;
			end
		end
		if (seen < n) begin
			other_errors++;
			$display("Timed out waiting for %0d sample strobes, saw %0d", n, seen);
		end
	endtask

	task automatic wait_status(input int bit_idx, input logic value, input int limit,
			input string what);
		int cycles;
		cycles = 0;
		while (dout[bit_idx] !== value && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (dout[bit_idx] !== value) begin
			other_errors++;
			$display("Timed out after %0d clocks waiting for %s", limit, what);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected 0x%02h, actual 0x%02h", name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_sample(input string name, input sample_t exp, input sample_t act);
		if (act !== exp) begin
			mismatches++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic check_magnitude(input string name, input int limit, input sample_t act);
		if ($isunknown(act) || act > limit || act < -limit) begin
			mismatches++;
			$display("MISMATCH %s: expected magnitude <= %0d, actual %0d", name, limit, act);
		end
	endtask

	`include "tb_fm_tests.svh"

	initial begin
		rst          = 1'b1;
		din          = '0;
		addr         = '0;
		cs_n         = 1'b1;
		wr_n         = 1'b1;
		mismatches   = 0;
		other_errors = 0;
		rng_state    = 32'd314;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		reset_test();
		busy_test();
		timer_a_test();
		timer_b_test();
		pan_key_test();
		attenuation_test();

		$display("Error counts: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// ==== fm_synth.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_synth (
	input  logic            clk,
	input  logic            rst,
	input  logic [7:0]      din,
	input  logic [1:0]      addr,
	input  logic            cs_n,
	input  logic            wr_n,
	output logic [7:0]      dout,
	output logic            irq_n,
	output fm_pkg::sample_t snd_left,
	output fm_pkg::sample_t snd_right,
	output logic            snd_sample
);

	import fm_pkg::*;

	localparam int PRESCALE_W = $clog2(`FM_TB_PRESCALE);

	ch_cfg_t           cfg;
	slot_t             ph_slot;
	slot_t             op_slot;
	logic signed [9:0] level;
	logic              frame;
	logic [9:0]        value_a;
	logic [7:0]        value_b;
	logic              load_a;
	logic              load_b;
	logic              clr_a;
	logic              clr_b;
	logic              flag_a;
	logic              flag_b;
	logic              tick_b;

	fm_regs u_regs (
		.clk     ( clk     ),
		.rst     ( rst     ),
		.din     ( din     ),
		.addr    ( addr    ),
		.cs_n    ( cs_n    ),
		.wr_n    ( wr_n    ),
		.flag_a  ( flag_a  ),
		.flag_b  ( flag_b  ),
		.dout    ( dout    ),
		.irq_n   ( irq_n   ),
		.frame   ( frame   ),
		.cfg     ( cfg     ),
		.value_a ( value_a ),
		.value_b ( value_b ),
		.load_a  ( load_a  ),
		.load_b  ( load_b  ),
		.clr_a   ( clr_a   ),
		.clr_b   ( clr_b   )
	);

	// Timer A ticks once per frame
	fm_timer #( .WIDTH(10) ) u_timer_a (
		.clk      ( clk     ),
		.rst      ( rst     ),
		.tick     ( frame   ),
		.load     ( load_a  ),
		.value    ( value_a ),
		.clr      ( clr_a   ),
		.flag     ( flag_a  ),
		.overflow (         )
	);

	// Free-running frame divider for timer B
	fm_timer #( .WIDTH(PRESCALE_W) ) u_prescale_b (
		.clk      ( clk    ),
		.rst      ( rst    ),
		.tick     ( frame  ),
		.load     ( 1'b1   ),
		.value    ( '0     ),
		.clr      ( 1'b0   ),
		.flag     (        ),
		.overflow ( tick_b )
	);

	fm_timer #( .WIDTH(8) ) u_timer_b (
		.clk      ( clk     ),
		.rst      ( rst     ),
		.tick     ( tick_b  ),
		.load     ( load_b  ),
		.value    ( value_b ),
		.clr      ( clr_b   ),
		.flag     ( flag_b  ),
		.overflow (         )
	);

	fm_phase u_phase (
		.clk  ( clk     ),
		.rst  ( rst     ),
		.cfg  ( cfg     ),
		.slot ( ph_slot )
	);

	fm_operator u_op (
		.clk      ( clk     ),
		.rst      ( rst     ),
		.slot_in  ( ph_slot ),
		.level    ( level   ),
		.slot_out ( op_slot )
	);

	fm_mixer u_mixer (
		.clk        ( clk        ),
		.rst        ( rst        ),
		.level      ( level      ),
		.slot       ( op_slot    ),
		.snd_left   ( snd_left   ),
		.snd_right  ( snd_right  ),
		.snd_sample ( snd_sample )
	);

endmodule

// ==== fm_mixer.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_mixer (
	input  logic              clk,
	input  logic              rst,
	input  logic signed [9:0] level,
	input  fm_pkg::slot_t     slot,
	output fm_pkg::sample_t   snd_left,
	output fm_pkg::sample_t   snd_right,
	output logic              snd_sample
);

	import fm_pkg::*;

	logic signed [13:0] sum_l;
	logic signed [13:0] sum_r;
	logic signed [13:0] next_l;
	logic signed [13:0] next_r;
	logic               last;

	// Clip the wide sum into the 12-bit output range
	function automatic sample_t saturate(input logic signed [13:0] v);
		sample_t s;
		if (v > 14'sd2047) begin
			s = 12'h7FF;
		end else if (v < -14'sd2048) begin
			s = 12'h800;
		end else begin
			s = v[11:0];
		end
		return s;
	endfunction

	assign last   = slot.slot == 2'(`FM_CHANNELS - 1);
	assign next_l = sum_l + (slot.pan_l ? 14'(level) : 14'sd0);
	assign next_r = sum_r + (slot.pan_r ? 14'(level) : 14'sd0);

	always_ff @(posedge clk) begin
		if (rst) begin
			sum_l      <= '0;
			sum_r      <= '0;
			snd_left   <= '0;
			snd_right  <= '0;
			snd_sample <= 1'b0;
		end else begin
			snd_sample <= last;
			if (last) begin
				// Frame complete, publish and start over
				snd_left  <= saturate(next_l);
				snd_right <= saturate(next_r);
				sum_l     <= '0;
				sum_r     <= '0;
			end else begin
				sum_l <= next_l;
				sum_r <= next_r;
			end
		end
	end

endmodule

// ==== fm_operator.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_operator (
	input  logic              clk,
	input  logic              rst,
	input  fm_pkg::slot_t     slot_in,
	output logic signed [9:0] level,
	output fm_pkg::slot_t     slot_out
);

	import fm_pkg::*;

	localparam int IDX_W = $clog2(`FM_SINE_SIZE);

	// First quarter of a sine, sampled at mid-points, peak 511
	localparam logic [8:0] SINE [`FM_SINE_SIZE] = '{
		9'd6,   9'd19,  9'd31,  9'd44,  9'd56,  9'd69,  9'd81,  9'd94,
		9'd106, 9'd118, 9'd130, 9'd142, 9'd154, 9'd166, 9'd178, 9'd190,
		9'd201, 9'd213, 9'd224, 9'd235, 9'd246, 9'd257, 9'd268, 9'd279,
		9'd289, 9'd299, 9'd309, 9'd319, 9'd329, 9'd338, 9'd348, 9'd357,
		9'd366, 9'd374, 9'd383, 9'd391, 9'd399, 9'd407, 9'd414, 9'd421,
		9'd428, 9'd435, 9'd441, 9'd448, 9'd454, 9'd459, 9'd465, 9'd470,
		9'd474, 9'd479, 9'd483, 9'd487, 9'd491, 9'd494, 9'd497, 9'd500,
		9'd502, 9'd505, 9'd506, 9'd508, 9'd509, 9'd510, 9'd511, 9'd511
	};

	logic [IDX_W-1:0] idx;
	logic [8:0]       tab_r;
	logic             sign_r;
	slot_t            slot_r;
	logic [8:0]       mag;

	// Odd quadrants read the table backwards
	assign idx = slot_in.phase[8] ? ~slot_in.phase[7 -: IDX_W] : slot_in.phase[7 -: IDX_W];

	always_ff @(posedge clk) begin
		if (rst) begin
			tab_r  <= '0;
			sign_r <= 1'b0;
			slot_r <= '0;
		end else begin
			tab_r  <= SINE[idx];
			// Second half of the cycle is negative
			sign_r <= slot_in.phase[9];
			slot_r <= slot_in;
		end
	end

	// Coarse attenuation, one halving per step of the top TL bits
	assign mag = tab_r >> slot_r.tl[6:4];

	always_ff @(posedge clk) begin
		if (rst) begin
			level    <= '0;
			slot_out <= '0;
		end else begin
			slot_out <= slot_r;
			if (!slot_r.keyon) begin
				level <= '0;
			end else if (sign_r) begin
				level <= -{1'b0, mag};
			end else begin
				level <= {1'b0, mag};
			end
		end
	end

endmodule

// ==== fm_phase.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_phase (
	input  logic            clk,
	input  logic            rst,
	input  fm_pkg::ch_cfg_t cfg,
	output fm_pkg::slot_t   slot
);

	logic [19:0] acc [`FM_CHANNELS];
	logic [19:0] inc;
	logic [19:0] acc_next;

	// Block works as an octave shift of the frequency number
	assign inc = {9'd0, cfg.fnum} << cfg.block;

	// Keyed off channels restart from phase zero
	assign acc_next = cfg.keyon ? acc[cfg.slot] + inc : 20'd0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int ch = 0; ch < `FM_CHANNELS; ch++) begin
				acc[ch] <= '0;
			end
		end else begin
			acc[cfg.slot] <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot <= '0;
		end else begin
			slot.phase <= acc_next[19:10];
			slot.tl    <= cfg.tl;
			slot.keyon <= cfg.keyon;
			slot.pan_l <= cfg.pan_l;
			slot.pan_r <= cfg.pan_r;
			slot.slot  <= cfg.slot;
		end
	end

endmodule

// ==== fm_timer.sv ====
`timescale 1ns/1ps

module fm_timer #(
	parameter int WIDTH = 10
) (
	input  logic             clk,
	input  logic             rst,
	input  logic             tick,
	input  logic             load,
	input  logic [WIDTH-1:0] value,
	input  logic             clr,
	output logic             flag,
	output logic             overflow
);

	logic [WIDTH-1:0] cnt;
	logic             wrap;

	// Last count before the counter rolls over
	assign wrap = load && tick && cnt == '1;

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt      <= '0;
			flag     <= 1'b0;
			overflow <= 1'b0;
		end else begin
			overflow <= wrap;
			// Stopped counter keeps tracking the start value
			if (!load || wrap) begin
				cnt <= value;
			end else if (tick) begin
				cnt <= cnt + 1'b1;
			end
			if (wrap) begin
				flag <= 1'b1;
			end else if (clr) begin
				flag <= 1'b0;
			end
		end
	end

endmodule

// ==== fm_regs.sv ====
`timescale 1ns/1ps
`include "fm_defs.svh"

module fm_regs (
	input  logic            clk,
	input  logic            rst,
	input  logic [7:0]      din,
	input  logic [1:0]      addr,
	input  logic            cs_n,
	input  logic            wr_n,
	input  logic            flag_a,
	input  logic            flag_b,
	output logic [7:0]      dout,
	output logic            irq_n,
	output logic            frame,
	output fm_pkg::ch_cfg_t cfg,
	output logic [9:0]      value_a,
	output logic [7:0]      value_b,
	output logic            load_a,
	output logic            load_b,
	output logic            clr_a,
	output logic            clr_b
);

	logic       write;
	logic       addr_wr;
	logic       data_wr;
	logic [7:0] reg_addr;
	logic [1:0] busy_cnt;
	logic       busy;
	logic       irq_en_a;
	logic       irq_en_b;
	logic [1:0] slot_cnt;

	// Channel register file
	logic [7:0] fnum_lo [`FM_CHANNELS];
	logic [2:0] fnum_hi [`FM_CHANNELS];
	logic [2:0] block   [`FM_CHANNELS];
	logic [6:0] tl      [`FM_CHANNELS];
	logic       keyon   [`FM_CHANNELS];
	logic       pan_l   [`FM_CHANNELS];
	logic       pan_r   [`FM_CHANNELS];

	assign write   = !cs_n && !wr_n;
	assign addr_wr = write && addr == 2'd0;
	assign data_wr = write && addr == 2'd1;

	always_ff @(posedge clk) begin
		if (rst) begin
			reg_addr <= '0;
		end else if (addr_wr) begin
			reg_addr <= din;
		end
	end

	// Busy holds for three clocks after each data write
	always_ff @(posedge clk) begin
		if (rst) begin
			busy_cnt <= '0;
		end else if (data_wr) begin
			busy_cnt <= 2'd3;
		end else if (busy_cnt != 2'd0) begin
			busy_cnt <= busy_cnt - 2'd1;
		end
	end

	assign busy = busy_cnt != 2'd0;

	// Timer values and control
	always_ff @(posedge clk) begin
		if (rst) begin
			value_a  <= '0;
			value_b  <= '0;
			load_a   <= 1'b0;
			load_b   <= 1'b0;
			irq_en_a <= 1'b0;
			irq_en_b <= 1'b0;
			clr_a    <= 1'b0;
			clr_b    <= 1'b0;
		end else begin
			clr_a <= 1'b0;
			clr_b <= 1'b0;
			if (data_wr) begin
				case (reg_addr)
					`FM_REG_TA_HI: value_a[9:2] <= din;
					`FM_REG_TA_LO: value_a[1:0] <= din[1:0];
					`FM_REG_TB:    value_b <= din;
					`FM_REG_TCTRL: begin
						load_a   <= din[0];
						load_b   <= din[1];
						irq_en_a <= din[2];
						irq_en_b <= din[3];
						// Flag reset bits only pulse
						clr_a    <= din[4];
						clr_b    <= din[5];
					end
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int ch = 0; ch < `FM_CHANNELS; ch++) begin
				fnum_lo[ch] <= '0;
				fnum_hi[ch] <= '0;
				block[ch]   <= '0;
				tl[ch]      <= '0;
				keyon[ch]   <= 1'b0;
				pan_l[ch]   <= 1'b1;
				pan_r[ch]   <= 1'b1;
			end
		end else if (data_wr) begin
			for (int ch = 0; ch < `FM_CHANNELS; ch++) begin
				if (reg_addr == 8'(`FM_REG_FNUM_LO + ch)) begin
					fnum_lo[ch] <= din;
				end
				if (reg_addr == 8'(`FM_REG_FNUM_HI + ch)) begin
					fnum_hi[ch] <= din[2:0];
					block[ch]   <= din[5:3];
				end
				if (reg_addr == 8'(`FM_REG_TL + ch)) begin
					tl[ch] <= din[6:0];
				end
				if (reg_addr == 8'(`FM_REG_PAN + ch)) begin
					pan_l[ch] <= din[7];
					pan_r[ch] <= din[6];
				end
				// Key register, channel in the low bits, operator mask above
				if (reg_addr == `FM_REG_KEY && din[1:0] == 2'(ch)) begin
					keyon[ch] <= |din[7:4];
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot_cnt <= '0;
		end else if (slot_cnt == 2'(`FM_CHANNELS - 1)) begin
			slot_cnt <= '0;
		end else begin
			slot_cnt <= slot_cnt + 2'd1;
		end
	end

	assign frame = slot_cnt == 2'd0;

	always_comb begin
		cfg.fnum  = {fnum_hi[slot_cnt], fnum_lo[slot_cnt]};
		cfg.block = block[slot_cnt];
		cfg.tl    = tl[slot_cnt];
		cfg.keyon = keyon[slot_cnt];
		cfg.pan_l = pan_l[slot_cnt];
		cfg.pan_r = pan_r[slot_cnt];
		cfg.slot  = slot_cnt;
	end

	assign dout  = {busy, 5'd0, flag_b, flag_a};
	assign irq_n = !((flag_a && irq_en_a) || (flag_b && irq_en_b));

endmodule

// ==== fm_pkg.sv ====
package fm_pkg;

	// Configuration of one channel as seen by the phase stage
	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [6:0]  tl;
		logic        keyon;
		logic        pan_l;
		logic        pan_r;
		logic [1:0]  slot;
	} ch_cfg_t;

	// Payload travelling down the operator pipeline
	typedef struct packed {
		// Top bits of the phase accumulator
		logic [9:0] phase;
		logic [6:0] tl;
		logic       keyon;
		logic       pan_l;
		logic       pan_r;
		logic [1:0] slot;
	} slot_t;

	// Stereo output word
	typedef logic signed [11:0] sample_t;

endpackage

// ==== fm_defs.svh ====
`ifndef FM_DEFS_SVH
`define FM_DEFS_SVH

// Channel slots in one frame
`define FM_CHANNELS 3

// Frames per timer B tick
`define FM_TB_PRESCALE 16

// Quarter-sine table entries
`define FM_SINE_SIZE 64

// Global registers
`define FM_REG_TA_HI 8'h24
`define FM_REG_TA_LO 8'h25
`define FM_REG_TB 8'h26
`define FM_REG_TCTRL 8'h27
`define FM_REG_KEY 8'h28

// Per-channel bases, channel index is added
`define FM_REG_FNUM_LO 8'hA0
`define FM_REG_FNUM_HI 8'hA4
`define FM_REG_TL 8'h40
`define FM_REG_PAN 8'hB4

`endif
